// ==== capi_pkg.sv ====
/*
  Coherent link types
  Half-line buffer write beat, completion response and response codes
*/
package capi_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Every command tag on the link is 8 bits
  parameter int TAG_WIDTH = 8;

  // A half line is eight 64-bit double words
  parameter int DW_WIDTH       = 64;
  parameter int DW_COUNT       = 8;
  parameter int HALF_LINE_BITS = DW_WIDTH * DW_COUNT;

  //////////////////////////////
  // Response codes
  //////////////////////////////

  // NLOCK means the line is not released yet
  typedef enum logic [2:0] {
    RESP_DONE   = 3'd0,
    RESP_NLOCK  = 3'd1,
    RESP_FAILED = 3'd2,
    RESP_PAGED  = 3'd3
  } resp_code_t;

  //////////////////////////////
  // Beats and responses
  //////////////////////////////

  // One half-line beat, parity bit i covers double word i
  typedef struct packed {
    logic                      write_valid;
    logic [TAG_WIDTH-1:0]      write_tag;
    logic                      write_tag_parity;
    logic                      write_address;
    logic [HALF_LINE_BITS-1:0] write_data;
    logic [DW_COUNT-1:0]       write_parity;
  } buffer_write_t;

  // Completion response for one tag
  typedef struct packed {
    logic                 valid;
    logic [TAG_WIDTH-1:0] tag;
    resp_code_t           code;
  } response_t;

endpackage

// ==== afu_pkg.sv ====
/*
  Accelerator side types
  Command types, tag table writes and the released half-line record
*/
package afu_pkg;

  //////////////////////////////
  // Command types
  //////////////////////////////

  // Only READ and WED commands return data on this path
  typedef enum logic [1:0] {
    CMD_INVALID = 2'd0,
    CMD_READ    = 2'd1,
    CMD_WED     = 2'd2,
    CMD_WRITE   = 2'd3
  } cmd_type_t;

  //////////////////////////////
  // Tag table write
  //////////////////////////////

  // Issued command, recorded by tag
  typedef struct packed {
    logic                           valid;
    logic [capi_pkg::TAG_WIDTH-1:0] tag;
    cmd_type_t                      cmd_type;
  } tag_issue_t;

  //////////////////////////////
  // Half-line record
  //////////////////////////////

  // Stored per tag and half, also the output format
  // read_data and wed_data are one-hot or both clear
  typedef struct packed {
    logic                                valid;
    logic                                read_data;
    logic                                wed_data;
    cmd_type_t                           cmd_type;
    logic [capi_pkg::TAG_WIDTH-1:0]      tag;
    logic [capi_pkg::HALF_LINE_BITS-1:0] data;
  } half_line_t;

  // Record width, sizes the half-line RAMs
  parameter int HALF_LINE_REC_BITS = $bits(half_line_t);

endpackage

// ==== tag_ram.sv ====
`timescale 1ns/1ns
/*
  Simple dual-port RAM
  One synchronous write port, one read port with a registered output
*/
module tag_ram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 256
) (
  input  logic                     clock,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  logic [WIDTH-1:0]         data_in,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output logic [WIDTH-1:0]         data_out
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clock) begin
    if (we) begin
      mem[wr_addr] <= data_in;
    end
  end

  // Read in the same cycle as a write returns the old word
  always_ff @(posedge clock) begin
    data_out <= mem[rd_addr];
  end

endmodule

// ==== command_tag_table.sv ====
`timescale 1ns/1ns
/*
  Command tag table
  Keeps the command type of every issued tag, two combinational lookups
*/
module command_tag_table #(
  parameter int TAG_COUNT = 256
) (
  input  logic                           clock,
  input  logic                           rstn,
  input  afu_pkg::tag_issue_t            tag_issue,
  input  logic [capi_pkg::TAG_WIDTH-1:0] beat_tag,
  output afu_pkg::cmd_type_t             beat_cmd_type,
  input  logic [capi_pkg::TAG_WIDTH-1:0] resp_tag,
  output afu_pkg::cmd_type_t             resp_cmd_type
);
  import afu_pkg::*;

  localparam int ADDR_WIDTH = $clog2(TAG_COUNT);

  cmd_type_t cmd_table [TAG_COUNT];

  //////////////////////////////
  // Table write
  //////////////////////////////

  // Entry holds until the same tag is issued again
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < TAG_COUNT; i++) begin
        cmd_table[i] <= CMD_INVALID;
      end
    end else if (tag_issue.valid) begin
      cmd_table[tag_issue.tag[ADDR_WIDTH-1:0]] <= tag_issue.cmd_type;
    end
  end

  //////////////////////////////
  // Lookups
  //////////////////////////////

  // Beat side, used to type the stored half
  assign beat_cmd_type = cmd_table[beat_tag[ADDR_WIDTH-1:0]];

  // Response side, gates the release
  assign resp_cmd_type = cmd_table[resp_tag[ADDR_WIDTH-1:0]];

endmodule

// ==== read_data_control.sv ====
`timescale 1ns/1ns
/*
  Read data controller
  Latches half-line beats, checks odd parity on tag and data, stores each
  half by tag and releases half 0 then half 1 on a completion response
*/
module read_data_control #(
  parameter int TAG_COUNT = 256
) (
  input  logic                           clock,
  input  logic                           rstn,
  input  logic                           enabled_in,
  input  capi_pkg::buffer_write_t        buffer_in,
  output logic [capi_pkg::TAG_WIDTH-1:0] beat_tag,
  input  afu_pkg::cmd_type_t             beat_cmd_type,
  output logic [capi_pkg::TAG_WIDTH-1:0] resp_tag,
  input  afu_pkg::cmd_type_t             resp_cmd_type,
  input  capi_pkg::response_t            response_in,
  output logic [1:0]                     data_read_error,
  output afu_pkg::half_line_t            half_out_0,
  output afu_pkg::half_line_t            half_out_1
);
  import capi_pkg::*;
  import afu_pkg::*;

  localparam int ADDR_WIDTH = $clog2(TAG_COUNT);

  logic                  enabled;
  logic                  beat_valid_q;
  buffer_write_t         beat_q;
  logic                  beat_is_line;

  // Half record on its way into RAM
  half_line_t            rec_q;
  logic                  rec_we_0;
  logic                  rec_we_1;
  logic [ADDR_WIDTH-1:0] rec_addr;

  logic                  tag_err_s1;
  logic                  data_err_s1;
  logic [1:0]            err_s2;

  logic [ADDR_WIDTH-1:0] rd_addr;
  logic                  release_q;
  half_line_t            ram_out_0;
  half_line_t            ram_out_1;
  half_line_t            half_1_stage;

  // Odd parity bit for a tag
  function automatic logic tag_parity(input logic [TAG_WIDTH-1:0] tag);
    return ~^tag;
  endfunction

  // One odd parity bit per double word, bit i covers double word i
  function automatic logic [DW_COUNT-1:0] dw_parity(
    input logic [HALF_LINE_BITS-1:0] data
  );
    logic [DW_COUNT-1:0] par;
    par = '0;
    for (int i = 0; i < DW_COUNT; i++) begin
      par[i] = ~^data[i*DW_WIDTH +: DW_WIDTH];
    end
    return par;
  endfunction

  //////////////////////////////
  // Enable and beat latch
  //////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled      <= 1'b0;
      beat_valid_q <= 1'b0;
    end else begin
      enabled      <= enabled_in;
      beat_valid_q <= enabled && buffer_in.write_valid;
    end
  end

  always_ff @(posedge clock) begin
    beat_q <= buffer_in;
  end

  assign beat_tag     = beat_q.write_tag;
  assign beat_is_line = (beat_cmd_type == CMD_READ) || (beat_cmd_type == CMD_WED);

  //////////////////////////////
  // Half record build
  //////////////////////////////

  // write_address picks the RAM, other command types are dropped
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rec_we_0 <= 1'b0;
      rec_we_1 <= 1'b0;
    end else begin
      rec_we_0 <= enabled && beat_valid_q && beat_is_line && !beat_q.write_address;
      rec_we_1 <= enabled && beat_valid_q && beat_is_line && beat_q.write_address;
    end
  end

  always_ff @(posedge clock) begin
    rec_q.valid     <= beat_valid_q;
    rec_q.read_data <= (beat_cmd_type == CMD_READ);
    rec_q.wed_data  <= (beat_cmd_type == CMD_WED);
    rec_q.cmd_type  <= beat_cmd_type;
    rec_q.tag       <= beat_q.write_tag;
    rec_q.data      <= beat_q.write_data;
  end

  assign rec_addr = rec_q.tag[ADDR_WIDTH-1:0];

  //////////////////////////////
  // Parity checks
  //////////////////////////////

  // Two stages after the check so errors line up three cycles after the beat
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_err_s1      <= 1'b0;
      data_err_s1     <= 1'b0;
      err_s2          <= 2'b00;
      data_read_error <= 2'b00;
    end else begin
      if (beat_valid_q) begin
        tag_err_s1  <= tag_parity(beat_q.write_tag) != beat_q.write_tag_parity;
        data_err_s1 <= |(dw_parity(beat_q.write_data) ^ beat_q.write_parity);
      end else begin
        tag_err_s1  <= 1'b0;
        data_err_s1 <= 1'b0;
      end
      err_s2          <= {tag_err_s1, data_err_s1};
      data_read_error <= enabled ? err_s2 : 2'b00;
    end
  end

  //////////////////////////////
  // Half-line RAMs
  //////////////////////////////

  tag_ram #(
    .WIDTH(HALF_LINE_REC_BITS),
    .DEPTH(TAG_COUNT)
  ) i_half_ram_0 (
    .clock   (clock),
    .we      (rec_we_0),
    .wr_addr (rec_addr),
    .data_in (rec_q),
    .rd_addr (rd_addr),
    .data_out(ram_out_0)
  );

  tag_ram #(
    .WIDTH(HALF_LINE_REC_BITS),
    .DEPTH(TAG_COUNT)
  ) i_half_ram_1 (
    .clock   (clock),
    .we      (rec_we_1),
    .wr_addr (rec_addr),
    .data_in (rec_q),
    .rd_addr (rd_addr),
    .data_out(ram_out_1)
  );

  //////////////////////////////
  // Release on response
  //////////////////////////////

  // Both RAMs are read straight off the response tag
  assign resp_tag = response_in.tag;
  assign rd_addr  = response_in.tag[ADDR_WIDTH-1:0];

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      release_q <= 1'b0;
    end else begin
      release_q <= enabled && response_in.valid && (response_in.code != RESP_NLOCK) &&
                   ((resp_cmd_type == CMD_READ) || (resp_cmd_type == CMD_WED));
    end
  end

  // Half 1 trails half 0 by one stage
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      half_out_0   <= '0;
      half_1_stage <= '0;
      half_out_1   <= '0;
    end else begin
      half_out_0   <= (enabled && release_q) ? ram_out_0 : '0;
      half_1_stage <= (enabled && release_q) ? ram_out_1 : '0;
      half_out_1   <= enabled ? half_1_stage : '0;
    end
  end

endmodule

// ==== read_data_path_top.sv ====
`timescale 1ns/1ns
/*
  Read data return path
  Command tag table plus read data controller
*/
module read_data_path_top #(
  parameter int TAG_COUNT = 256
) (
  input  logic                    clock,
  input  logic                    rstn,
  input  logic                    enabled_in,
  input  afu_pkg::tag_issue_t     tag_issue,
  input  capi_pkg::buffer_write_t buffer_in,
  input  capi_pkg::response_t     response_in,
  output afu_pkg::half_line_t     half_out_0,
  output afu_pkg::half_line_t     half_out_1,
  output logic [1:0]              data_read_error
);

  // Lookups between the controller and the table
  logic [capi_pkg::TAG_WIDTH-1:0] beat_tag;
  logic [capi_pkg::TAG_WIDTH-1:0] resp_tag;
  afu_pkg::cmd_type_t             beat_cmd_type;
  afu_pkg::cmd_type_t             resp_cmd_type;

  command_tag_table #(
    .TAG_COUNT(TAG_COUNT)
  ) i_command_tag_table (
    .clock        (clock),
    .rstn         (rstn),
    .tag_issue    (tag_issue),
    .beat_tag     (beat_tag),
    .beat_cmd_type(beat_cmd_type),
    .resp_tag     (resp_tag),
    .resp_cmd_type(resp_cmd_type)
  );

  read_data_control #(
    .TAG_COUNT(TAG_COUNT)
  ) i_read_data_control (
    .clock          (clock),
    .rstn           (rstn),
    .enabled_in     (enabled_in),
    .buffer_in      (buffer_in),
    .beat_tag       (beat_tag),
    .beat_cmd_type  (beat_cmd_type),
    .resp_tag       (resp_tag),
    .resp_cmd_type  (resp_cmd_type),
    .response_in    (response_in),
    .data_read_error(data_read_error),
    .half_out_0     (half_out_0),
    .half_out_1     (half_out_1)
  );

endmodule

// ==== read_data_path_checker.sv ====
`timescale 1ns/1ns
/*
  Read data path checker
  Assertions on the released halves and the parity error output
*/
module read_data_path_checker (
  input logic                clock,
  input logic                rstn,
  input logic                enabled_in,
  input afu_pkg::half_line_t half_out_0,
  input afu_pkg::half_line_t half_out_1,
  input logic [1:0]          data_read_error
);

  // Half 1 one cycle behind half 0, unless the registered enable drops in between
  pair_follows: assert property (@(posedge clock) disable iff (!rstn)
    (half_out_0.valid && $past(enabled_in)) |=> half_out_1.valid)
    else $error("half_out_1 did not follow half_out_0");

  // Read and WED flags one-hot
  flags_exclusive: assert property (@(posedge clock) disable iff (!rstn)
    !(half_out_0.read_data && half_out_0.wed_data) &&
    !(half_out_1.read_data && half_out_1.wed_data))
    else $error("read_data and wed_data both set");

  zero_after_reset: assert property (@(posedge clock)
    $rose(rstn) |-> (half_out_0 == '0 && half_out_1 == '0 && data_read_error == 2'b00))
    else $error("outputs not zero after reset");

  // Error output goes through the registered enable
  no_error_disabled: assert property (@(posedge clock) disable iff (!rstn)
    !$past(enabled_in, 2) |-> data_read_error == 2'b00)
    else $error("data_read_error set while disabled");

endmodule

bind read_data_path_top read_data_path_checker i_read_data_path_checker (
  .clock          (clock),
  .rstn           (rstn),
  .enabled_in     (enabled_in),
  .half_out_0     (half_out_0),
  .half_out_1     (half_out_1),
  .data_read_error(data_read_error)
);

// ==== read_data_path_tb.sv ====
`timescale 1ns/1ns
/*
  Read data path testbench
  Replays the case file, models stored halves and errors, checks the outputs
*/
module read_data_path_tb;
  import capi_pkg::*;
  import afu_pkg::*;

  localparam int TAG_COUNT = 256;
  localparam int CMP_BITS  = $bits(half_line_t);

  logic            clock;
  logic            rstn;
  logic            enabled_in;
  tag_issue_t      tag_issue;
  buffer_write_t   buffer_in;
  response_t       response_in;
  half_line_t      half_out_0;
  half_line_t      half_out_1;
  logic [1:0]      data_read_error;

  // Reference model state
  cmd_type_t       tag_type [TAG_COUNT];
  half_line_t      model_half [TAG_COUNT][2];
  half_line_t      exp_h0 [int];
  half_line_t      exp_h1 [int];
  logic [1:0]      exp_err [int];

  int              cycle;
  int              last_beat_cycle;
  int              errors;
  logic [15:0]     lfsr;
  string           lines [$];
  string           line;
  int              fd;
  int              timeout_cycles;
  byte             op;
  integer          a;
  integer          b;
  integer          c;
  integer          d;
  half_line_t      want_0;
  half_line_t      want_1;
  logic [1:0]      want_err;

  read_data_path_top #(
    .TAG_COUNT(TAG_COUNT)
  ) i_read_data_path_top (
    .clock          (clock),
    .rstn           (rstn),
    .enabled_in     (enabled_in),
    .tag_issue      (tag_issue),
    .buffer_in      (buffer_in),
    .response_in    (response_in),
    .half_out_0     (half_out_0),
    .half_out_1     (half_out_1),
    .data_read_error(data_read_error)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  task automatic check_equal(input string what, input logic [CMP_BITS-1:0] got,
                             input logic [CMP_BITS-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic clear_inputs();
    tag_issue   = '0;
    buffer_in   = '0;
    response_in = '0;
  endtask

  task automatic send_beat(input int tag, input int half, input int tag_bad,
                           input int data_bad);
    logic [HALF_LINE_BITS-1:0] data;
    logic [DW_COUNT-1:0]       par;
    half_line_t                rec;
    logic                      tag_flip;
    logic                      data_flip;
    for (int i = 0; i < HALF_LINE_BITS; i++) begin
      lfsr    = lfsr_next(lfsr);
      data[i] = lfsr[0];
    end
    // Odd parity per double word, before any corruption
    for (int i = 0; i < DW_COUNT; i++) begin
      par[i] = ~^data[i*DW_WIDTH +: DW_WIDTH];
    end
    // A beat sent while disabled carries bad parity, so a leaked beat shows as an error
    tag_flip  = (tag_bad != 0) || !enabled_in;
    data_flip = (data_bad != 0) || !enabled_in;
    buffer_in.write_valid      = 1'b1;
    buffer_in.write_tag        = tag[7:0];
    buffer_in.write_tag_parity = (~^tag[7:0]) ^ tag_flip;
    buffer_in.write_address    = half[0];
    buffer_in.write_data       = data;
    buffer_in.write_parity     = par ^ {{(DW_COUNT-1){1'b0}}, data_flip};
    last_beat_cycle            = cycle;
    if (enabled_in && (tag_type[tag] == CMD_READ || tag_type[tag] == CMD_WED)) begin
      rec           = '0;
      rec.valid     = 1'b1;
      rec.read_data = (tag_type[tag] == CMD_READ);
      rec.wed_data  = (tag_type[tag] == CMD_WED);
      rec.cmd_type  = tag_type[tag];
      rec.tag       = tag[7:0];
      rec.data      = data;
      model_half[tag][half[0]] = rec;
    end
  endtask

  task automatic send_response(input int tag, input int code);
    response_in.valid = 1'b1;
    response_in.tag   = tag[7:0];
    response_in.code  = resp_code_t'(code[2:0]);
    // NLOCK keeps the halves in the RAMs
    if (enabled_in && code != RESP_NLOCK &&
        (tag_type[tag] == CMD_READ || tag_type[tag] == CMD_WED)) begin
      exp_h0[cycle + 2] = model_half[tag][0];
      exp_h1[cycle + 3] = model_half[tag][1];
    end
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  always @(negedge clock) begin
    if (rstn) begin
      want_0   = exp_h0.exists(cycle) ? exp_h0[cycle] : '0;
      want_1   = exp_h1.exists(cycle) ? exp_h1[cycle] : '0;
      want_err = exp_err.exists(cycle) ? exp_err[cycle] : 2'b00;
      check_equal("half_out_0", half_out_0, want_0);
      check_equal("half_out_1", half_out_1, want_1);
      check_equal("data_read_error", CMP_BITS'(data_read_error), CMP_BITS'(want_err));
    end
  end

  //////////////////////////////
  // Case replay
  //////////////////////////////

  initial begin
    clock           = 1'b0;
    rstn            = 1'b0;
    enabled_in      = 1'b0;
    cycle           = 0;
    errors          = 0;
    last_beat_cycle = 0;
    lfsr            = 16'd18011;
    clear_inputs();
    for (int i = 0; i < TAG_COUNT; i++) begin
      tag_type[i]      = CMD_INVALID;
      model_half[i][0] = '0;
      model_half[i][1] = '0;
    end

    fd = $fopen("read_data_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open read_data_cases.txt, no cases were run");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) && line.len() > 1 && line[0] != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end

    timeout_cycles = lines.size() * 20 + 50;
    fork
      begin
        repeat (timeout_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the run did not finish", timeout_cycles);
        $display("SOME TESTS FAILED");
        $finish;
      end
    join_none

    repeat (5) @(posedge clock);
    @(negedge clock);
    rstn       = 1'b1;
    enabled_in = 1'b1;

    foreach (lines[n]) begin
      a = 0;
      b = 0;
      c = 0;
      d = 0;
      void'($sscanf(lines[n], "%c %h %h %h %h", op, a, b, c, d));
      if (op == "E") begin
        // Error pair for the beat just above
        exp_err[last_beat_cycle + 4] = {a[0], b[0]};
      end else begin
        @(negedge clock);
        clear_inputs();
        case (op)
          "I": begin
            tag_issue.valid    = 1'b1;
            tag_issue.tag      = a[7:0];
            tag_issue.cmd_type = cmd_type_t'(b[1:0]);
            tag_type[a]        = cmd_type_t'(b[1:0]);
          end
          "B": send_beat(a, b, c, d);
          "R": send_response(a, b);
          "N": enabled_in = a[0];
          "W": begin
            repeat (a - 1) begin
              @(negedge clock);
            end
          end
          default: begin
            errors++;
            $display("Unknown opcode in case line: %s", lines[n]);
          end
        endcase
      end
    end

    @(negedge clock);
    clear_inputs();
    repeat (8) @(negedge clock);
    $display("Checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== read_data_cases.txt ====
# I tag type(1 read 2 wed 3 write) | B tag half tag_bad data_bad | R tag code(0 done 1 nlock)
# W cycles | N enable | E tag_err data_err for the beat above, all fields hex
I 10 1
B 10 0 0 0
B 10 1 0 0
W 3
R 10 0
W 4
I 20 2
B 20 1 0 0
B 20 0 0 0
W 3
R 20 0
W 4
I 30 1
B 30 0 1 0
E 1 0
B 30 1 0 1
E 0 1
W 3
R 30 1
W 4
R 30 0
W 4
I 41 1
I 42 2
B 41 0 0 0
B 42 0 0 0
B 41 1 0 0
B 42 1 0 0
W 3
R 41 0
R 42 0
W 4
I 50 3
B 50 0 0 0
B 50 1 0 0
W 3
R 50 0
W 4
N 0
B 10 0 0 0
B 10 1 0 0
N 1
W 3
R 10 0
W 5

// ==== build.f ====
capi_pkg.sv
afu_pkg.sv
tag_ram.sv
command_tag_table.sv
read_data_control.sv
read_data_path_top.sv
read_data_path_checker.sv
read_data_path_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the read data path testbench with Verilator
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module read_data_path_tb -o read_data_path_sim \
  && { ./obj_dir/read_data_path_sim > "$LOG" 2>&1 || echo "SOME TESTS FAILED" >> "$LOG"; } \
  || { echo "Verilator build failed"; exit 1; }

cat "$LOG"
grep -q "SOME TESTS FAILED" "$LOG" && { echo "Result: FAIL"; exit 1; } || echo "Result: PASS"
